// ==== source/sys_video_pkg.sv ====
// Video sync and host control core, shared definitions
// Data widths, the host command set and the bit positions used
// by the host port and the LED mixing.

package sys_video_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	// Host data word
	localparam int IO_W = 16;

	// Line counts and the vsync line offset
	localparam int LINE_W = 12;

	// Board LED bus
	localparam int LED_W = 8;

	// Period counters in polarity fix and composite sync
	localparam int PERIOD_W = 16;

	////////////////////////////////////////////////////////////
	// Bit positions
	////////////////////////////////////////////////////////////

	// Composite sync enable in the configuration word
	localparam int CFG_CSYNC_BIT = 3;

	// Default LED pattern
	localparam int LED_USER_BIT  = 0;
	localparam int LED_DISK_BIT  = 2;
	localparam int LED_POWER_BIT = 4;

	typedef logic [LINE_W-1:0] line_t;
	typedef logic [IO_W-1:0]   io_word_t;

	// Host commands, other byte values are accepted and ignored
	typedef enum logic [7:0] {
		CMD_CFG     = 8'h01,
		CMD_LED     = 8'h25,
		CMD_VS_WAIT = 8'h30,
		CMD_VS_LINE = 8'h38
	} host_cmd_e;

endpackage

// ==== source/video_if.sv ====
// Aligned sync bundle
// Horizontal, vertical and composite sync plus DE, all in step,
// from the composite sync generator to the output stage.

`timescale 1ns/1ps

interface video_if;
	logic hs;
	logic vs;
	logic de;
	logic cs;

	// Generator side
	modport src (output hs, output vs, output de, output cs);

	// Output register side
	modport snk (input hs, input vs, input de, input cs);

endinterface

// ==== source/host_ctrl.sv ====
// Host command port
// Level-toggle strobe with a two-cycle acknowledge echo, command
// and data word tracking, and the settings used by the video path.
// Wait-for-vsync holds the acknowledge fall until the next frame.

`timescale 1ns/1ps

module host_ctrl (
	input  logic                            clk_sys,
	input  logic                            resetd,
	input  logic                            i_io_clk,
	input  logic                            i_io_uio,
	input  sys_video_pkg::io_word_t         i_io_din,
	input  logic                            i_vs_rise,
	input  logic                            i_led_user,
	input  logic                            i_led_disk,
	input  logic                            i_led_power,
	output logic                            o_io_ack,
	output logic                            o_csync_en,
	output sys_video_pkg::line_t            o_vs_line,
	output logic [sys_video_pkg::LED_W-1:0] o_led
);
	import sys_video_pkg::*;

	logic             ack_q;
	logic             io_strobe;
	logic             hold_ack;
	logic             vs_wait;
	logic             has_cmd;
	host_cmd_e        cmd;
	logic [LED_W-1:0] led_overtake;
	logic [LED_W-1:0] led_state;
	logic [LED_W-1:0] led_default;

	// Strobe line high but not yet echoed
	assign io_strobe = i_io_clk & ~ack_q;
	assign hold_ack  = vs_wait & ~i_vs_rise;

	////////////////////////////////////////////////////////////
	// Acknowledge
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			ack_q    <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			ack_q <= i_io_clk;
			// Rise always passes, fall waits for vsync
			if (ack_q || !hold_ack) begin
				o_io_ack <= ack_q;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Command decode
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd      <= 1'b0;
			cmd          <= host_cmd_e'(8'h00);
			vs_wait      <= 1'b0;
			o_csync_en   <= 1'b0;
			o_vs_line    <= '0;
			led_overtake <= '0;
			led_state    <= '0;
		end else begin
			if (i_vs_rise) begin
				vs_wait <= 1'b0;
			end
			if (!i_io_uio) begin
				has_cmd <= 1'b0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					// First word of a transaction is the command byte
					has_cmd <= 1'b1;
					cmd     <= host_cmd_e'(i_io_din[7:0]);
					if (i_io_din[7:0] == CMD_VS_WAIT) begin
						vs_wait <= 1'b1;
					end
				end else begin
					case (cmd)
						CMD_CFG:     o_csync_en <= i_io_din[CFG_CSYNC_BIT];
						CMD_LED:     {led_overtake, led_state} <= i_io_din;
						CMD_VS_LINE: o_vs_line <= i_io_din[LINE_W-1:0];
						default:     ;
					endcase
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// LED mixing
	////////////////////////////////////////////////////////////

	always_comb begin
		led_default                = '0;
		led_default[LED_USER_BIT]  = i_led_user;
		led_default[LED_DISK_BIT]  = i_led_disk;
		led_default[LED_POWER_BIT] = i_led_power;
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_led <= '0;
		end else begin
			o_led <= (led_overtake & led_state) | (~led_overtake & led_default);
		end
	end

endmodule

// ==== source/sync_polarity_fix.sv ====
// Sync polarity normalization
// Measures the high and low time of a sync and flips it when the
// high time is the longer one, so the pulse comes out active high.

`timescale 1ns/1ps

module sync_polarity_fix (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);
	import sys_video_pkg::*;

	logic [PERIOD_W-1:0] cnt;
	logic [PERIOD_W-1:0] high_len;
	logic [PERIOD_W-1:0] low_len;
	logic                sync_q;
	logic                pol;

	assign o_sync = i_sync ^ pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			sync_q   <= 1'b0;
			cnt      <= '0;
			high_len <= '0;
			low_len  <= '0;
			pol      <= 1'b0;
		end else begin
			sync_q <= i_sync;
			// Restart on every edge, stick at full scale
			if (sync_q != i_sync) begin
				cnt <= '0;
			end else if (~&cnt) begin
				cnt <= cnt + PERIOD_W'(1);
			end
			if (~sync_q & i_sync) begin
				low_len <= cnt;
			end
			if (sync_q & ~i_sync) begin
				high_len <= cnt;
			end
			pol <= high_len > low_len;
		end
	end

endmodule

// ==== source/csync_gen.sv ====
// Composite sync generator
// Outside vsync the composite sync follows hsync. During vsync the
// pulse is moved by one hsync width, giving the serrated form.
// hs, vs and de are delayed one cycle to stay aligned with cs.

`timescale 1ns/1ps

module csync_gen (
	input  logic  clk_sys,
	input  logic  resetd,
	input  logic  i_hs,
	input  logic  i_vs,
	input  logic  i_de,
	video_if.src  o_vid
);
	import sys_video_pkg::*;

	logic [PERIOD_W-1:0] h_cnt;
	logic [PERIOD_W-1:0] line_len;
	logic [PERIOD_W-1:0] hs_len;
	logic                prev_hs;
	logic                cs_hs;
	logic                cs_vs;

	assign o_vid.cs = cs_vs ^ cs_hs;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
			prev_hs  <= 1'b0;
			cs_hs    <= 1'b0;
			cs_vs    <= 1'b0;
			o_vid.hs <= 1'b0;
			o_vid.vs <= 1'b0;
			o_vid.de <= 1'b0;
		end else begin
			// Line and hsync length
			h_cnt   <= h_cnt + PERIOD_W'(1);
			prev_hs <= i_hs;
			if (prev_hs != i_hs) begin
				h_cnt <= '0;
				if (i_hs) begin
					line_len <= h_cnt - hs_len;
					cs_hs    <= 1'b0;
				end else begin
					hs_len <= h_cnt;
				end
			end

			if (!i_vs) begin
				cs_hs <= i_hs;
			end else if (h_cnt == line_len) begin
				cs_hs <= 1'b1;
			end
			cs_vs <= i_vs;

			o_vid.hs <= i_hs;
			o_vid.vs <= i_vs;
			o_vid.de <= i_de;
		end
	end

endmodule

// ==== source/line_sync_marker.sv ====
// Line sync marker
// Counts hsync rising edges and takes the second blank line in a
// row as the frame boundary. Flags the line lying i_vs_line lines
// before that boundary.

`timescale 1ns/1ps

module line_sync_marker (
	input  logic                 clk_sys,
	input  logic                 resetd,
	input  logic                 i_hs,
	input  logic                 i_de,
	input  sys_video_pkg::line_t i_vs_line,
	output logic                 o_video_sync
);
	import sys_video_pkg::*;

	line_t      line_cnt;
	line_t      sync_line;
	logic [1:0] blank_cnt;
	logic       hs_q;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			line_cnt     <= '0;
			sync_line    <= '0;
			blank_cnt    <= '0;
			hs_q         <= 1'b0;
			o_video_sync <= 1'b0;
		end else begin
			hs_q <= i_hs;
			if (~hs_q & i_hs) begin
				o_video_sync <= (sync_line == line_cnt);
				line_cnt     <= line_cnt + LINE_W'(1);
				// Second line without DE closes the frame
				if (~blank_cnt[1]) begin
					blank_cnt <= blank_cnt + 2'd1;
					if (blank_cnt[0]) begin
						sync_line <= line_cnt - i_vs_line;
						line_cnt  <= '0;
					end
				end
			end
			if (i_de) begin
				blank_cnt <= '0;
			end
		end
	end

endmodule

// ==== source/video_out.sv ====
// Transmitter output stage
// Picks separate or composite horizontal sync, registers the sync
// and DE through two stages and flags the rising edge of the
// outgoing vsync for the host port.

`timescale 1ns/1ps

module video_out (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_csync_en,
	video_if.snk i_vid,
	output logic o_tx_hs,
	output logic o_tx_vs,
	output logic o_tx_de,
	output logic o_vs_rise
);

	logic hs_s1;
	logic vs_s1;
	logic de_s1;
	logic vs_prev;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hs_s1   <= 1'b0;
			vs_s1   <= 1'b0;
			de_s1   <= 1'b0;
			o_tx_hs <= 1'b0;
			o_tx_vs <= 1'b0;
			o_tx_de <= 1'b0;
			vs_prev <= 1'b0;
		end else begin
			// Sync select
			hs_s1 <= i_csync_en ? i_vid.cs : i_vid.hs;
			vs_s1 <= i_vid.vs;
			de_s1 <= i_vid.de;

			o_tx_hs <= hs_s1;
			o_tx_vs <= vs_s1;
			o_tx_de <= de_s1;

			vs_prev <= o_tx_vs;
		end
	end

	// One cycle on the first high cycle of o_tx_vs
	assign o_vs_rise = o_tx_vs & ~vs_prev;

endmodule

// ==== source/sys_video_top.sv ====
// Video sync and host control core
// Host command port, sync polarity fix, composite sync, line
// marker and the transmitter output registers on one clock.

`timescale 1ns/1ps

module sys_video_top (
	input  logic                            clk_sys,
	input  logic                            resetd,
	input  logic                            i_hs,
	input  logic                            i_vs,
	input  logic                            i_de,
	input  logic                            i_io_clk,
	input  logic                            i_io_uio,
	input  sys_video_pkg::io_word_t         i_io_din,
	input  logic                            i_led_user,
	input  logic                            i_led_disk,
	input  logic                            i_led_power,
	output logic                            o_io_ack,
	output logic                            o_tx_hs,
	output logic                            o_tx_vs,
	output logic                            o_tx_de,
	output logic                            o_video_sync,
	output logic [sys_video_pkg::LED_W-1:0] o_led
);
	import sys_video_pkg::*;

	logic  hs_fix;
	logic  vs_fix;
	logic  csync_en;
	logic  vs_rise;
	line_t vs_line;

	video_if vid_bus ();

	////////////////////////////////////////////////////////////
	// Input side
	////////////////////////////////////////////////////////////

	host_ctrl host_ctrl_inst (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_clk    (i_io_clk),
		.i_io_uio    (i_io_uio),
		.i_io_din    (i_io_din),
		.i_vs_rise   (vs_rise),
		.i_led_user  (i_led_user),
		.i_led_disk  (i_led_disk),
		.i_led_power (i_led_power),
		.o_io_ack    (o_io_ack),
		.o_csync_en  (csync_en),
		.o_vs_line   (vs_line),
		.o_led       (o_led)
	);

	sync_polarity_fix sync_fix_h_inst (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs),
		.o_sync  (hs_fix)
	);

	sync_polarity_fix sync_fix_v_inst (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vs),
		.o_sync  (vs_fix)
	);

	////////////////////////////////////////////////////////////
	// Processing and output
	////////////////////////////////////////////////////////////

	csync_gen csync_gen_inst (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_hs    (hs_fix),
		.i_vs    (vs_fix),
		.i_de    (i_de),
		.o_vid   (vid_bus)
	);

	line_sync_marker line_sync_marker_inst (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_hs         (hs_fix),
		.i_de         (i_de),
		.i_vs_line    (vs_line),
		.o_video_sync (o_video_sync)
	);

	video_out video_out_inst (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_csync_en (csync_en),
		.i_vid      (vid_bus),
		.o_tx_hs    (o_tx_hs),
		.o_tx_vs    (o_tx_vs),
		.o_tx_de    (o_tx_de),
		.o_vs_rise  (vs_rise)
	);

endmodule

// ==== tests/sys_video_assertions.sv ====
// Video core checker
// Concurrent checks on reset values, LED mixing, the sync path,
// the vsync wait on the host acknowledge and the line marker.
// Bound to the RTL top level.

`timescale 1ns/1ps

module sys_video_assertions (
	input logic                            clk_sys,
	input logic                            resetd,
	input logic                            i_hs,
	input logic                            i_vs,
	input logic                            i_de,
	input logic                            i_io_clk,
	input logic                            i_io_uio,
	input sys_video_pkg::io_word_t         i_io_din,
	input logic                            i_led_user,
	input logic                            i_led_disk,
	input logic                            i_led_power,
	input logic                            o_io_ack,
	input logic                            o_tx_hs,
	input logic                            o_tx_vs,
	input logic                            o_tx_de,
	input logic                            o_video_sync,
	input logic [sys_video_pkg::LED_W-1:0] o_led
);
	import sys_video_pkg::*;

	int               fail_cnt = 0;
	int               frames;
	int               line_frames;
	logic             hs_d;
	logic             vs_d;
	logic             io_clk_d;
	logic             tx_vs_d;
	logic             has_cmd;
	logic [7:0]       cmd;
	logic             waiting;
	logic             vs_seen;
	logic [LED_W-1:0] exp_led;
	logic             csync_on;
	line_t            vs_line_exp;
	line_t            line_idx;
	line_t            frame_lines;
	logic             strobe;
	logic             led_strobe;
	logic             cfg_strobe;
	logic             line_strobe;
	logic             wait_strobe;
	logic             hs_start;
	logic             vs_start;
	logic             settled;
	logic             mark_ok;
	line_t            mark_line;

	// Takeover in the upper byte, LED state in the lower byte
	function automatic logic [LED_W-1:0] led_mix(input io_word_t w, input logic u,
		input logic d, input logic p);
		logic [LED_W-1:0] dflt;
		logic [LED_W-1:0] res;
		dflt    = '0;
		dflt[0] = u;
		dflt[2] = d;
		dflt[4] = p;
		for (int i = 0; i < LED_W; i++) begin
			res[i] = w[LED_W+i] ? w[i] : dflt[i];
		end
		return res;
	endfunction

	assign strobe      = i_io_clk & ~io_clk_d & i_io_uio;
	assign led_strobe  = strobe & has_cmd & (cmd == CMD_LED);
	assign cfg_strobe  = strobe & has_cmd & (cmd == CMD_CFG);
	assign line_strobe = strobe & has_cmd & (cmd == CMD_VS_LINE);
	assign wait_strobe = strobe & ~has_cmd & (i_io_din[7:0] == CMD_VS_WAIT);
	assign hs_start    = hs_d & ~i_hs;
	assign vs_start    = vs_d & ~i_vs;
	assign settled     = frames >= 3;
	assign mark_ok     = settled & (line_frames >= 2);
	assign mark_line   = frame_lines - LINE_W'(1) - vs_line_exp;

	////////////////////////////////////////////////////////////
	// Reference state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			frames      <= 0;
			line_frames <= 0;
			hs_d        <= 1'b1;
			vs_d        <= 1'b1;
			io_clk_d    <= 1'b0;
			tx_vs_d     <= 1'b0;
			has_cmd     <= 1'b0;
			cmd         <= 8'h00;
			waiting     <= 1'b0;
			vs_seen     <= 1'b0;
			exp_led     <= '0;
			csync_on    <= 1'b0;
			vs_line_exp <= '0;
			line_idx    <= '0;
			frame_lines <= '0;
		end else begin
			hs_d      <= i_hs;
			vs_d      <= i_vs;
			io_clk_d  <= i_io_clk;
			tx_vs_d   <= o_tx_vs;
			// Line index counted from the start of vsync
			if (hs_start) begin
				if (vs_start) begin
					line_idx    <= '0;
					frame_lines <= line_idx + LINE_W'(1);
					if (frames < 15) begin
						frames <= frames + 1;
					end
					if (line_frames < 15) begin
						line_frames <= line_frames + 1;
					end
				end else begin
					line_idx <= line_idx + LINE_W'(1);
				end
			end
			// New line offset from the host
			if (line_strobe) begin
				vs_line_exp <= i_io_din[LINE_W-1:0];
				line_frames <= 0;
			end
			if (cfg_strobe) begin
				csync_on <= i_io_din[CFG_CSYNC_BIT];
			end

			if (!i_io_uio) begin
				has_cmd <= 1'b0;
			end else if (strobe && !has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= i_io_din[7:0];
			end
			if (led_strobe) begin
				exp_led <= led_mix(i_io_din, i_led_user, i_led_disk, i_led_power);
			end

			if (waiting && o_tx_vs && !tx_vs_d) begin
				vs_seen <= 1'b1;
			end
			if (waiting && vs_seen && !o_io_ack) begin
				waiting <= 1'b0;
			end
			if (wait_strobe) begin
				waiting <= 1'b1;
				vs_seen <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	a_reset_low: assert property (@(posedge clk_sys)
		$fell(resetd) |-> !(o_io_ack | o_tx_hs | o_tx_vs | o_tx_de | o_video_sync))
	else begin
		$error("** Error %0t outputs are not all low after reset", $time);
		fail_cnt = fail_cnt + 1;
	end

	a_led_mix: assert property (@(posedge clk_sys) disable iff (resetd)
		$past(led_strobe, 2) |-> (o_led == exp_led))
	else begin
		$error("** Error %0t o_led exp %h got %h", $time, exp_led, o_led);
		fail_cnt = fail_cnt + 1;
	end

	a_tx_vs: assert property (@(posedge clk_sys) disable iff (resetd || !settled)
		o_tx_vs == !$past(i_vs, 3))
	else begin
		$error("** Error %0t o_tx_vs exp %b got %b", $time, !$past(i_vs, 3), o_tx_vs);
		fail_cnt = fail_cnt + 1;
	end

	a_tx_de: assert property (@(posedge clk_sys) disable iff (resetd || !settled)
		o_tx_de == $past(i_de, 3))
	else begin
		$error("** Error %0t o_tx_de exp %b got %b", $time, $past(i_de, 3), o_tx_de);
		fail_cnt = fail_cnt + 1;
	end

	// Composite sync matches hsync while vsync is inactive
	a_tx_hs: assert property (@(posedge clk_sys) disable iff (resetd || !settled)
		(!$past(csync_on, 2) || $past(i_vs, 3)) |-> (o_tx_hs == !$past(i_hs, 3)))
	else begin
		$error("** Error %0t o_tx_hs exp %b got %b", $time, !$past(i_hs, 3), o_tx_hs);
		fail_cnt = fail_cnt + 1;
	end

	a_ack_echo: assert property (@(posedge clk_sys) disable iff (resetd)
		(!waiting && !$past(waiting, 3)) |-> (o_io_ack == $past(i_io_clk, 2)))
	else begin
		$error("** Error %0t o_io_ack exp %b got %b", $time, $past(i_io_clk, 2), o_io_ack);
		fail_cnt = fail_cnt + 1;
	end

	a_wait_hold: assert property (@(posedge clk_sys) disable iff (resetd)
		(waiting && !vs_seen) |-> !$fell(o_io_ack))
	else begin
		$error("** Error %0t o_io_ack fell before the vsync rise", $time);
		fail_cnt = fail_cnt + 1;
	end

	a_wait_release: assert property (@(posedge clk_sys) disable iff (resetd)
		(waiting && $rose(o_tx_vs) && !i_io_clk && !$past(i_io_clk)) |=> !o_io_ack)
	else begin
		$error("** Error %0t o_io_ack still high after the vsync rise", $time);
		fail_cnt = fail_cnt + 1;
	end

	a_line_mark: assert property (@(posedge clk_sys) disable iff (resetd || !mark_ok)
		$past(hs_start) |-> (o_video_sync == (line_idx == mark_line)))
	else begin
		$error("** Error %0t o_video_sync exp %b got %b", $time,
			line_idx == mark_line, o_video_sync);
		fail_cnt = fail_cnt + 1;
	end

endmodule

bind sys_video_top sys_video_assertions sys_video_assertions_inst (
	.clk_sys      (clk_sys),
	.resetd       (resetd),
	.i_hs         (i_hs),
	.i_vs         (i_vs),
	.i_de         (i_de),
	.i_io_clk     (i_io_clk),
	.i_io_uio     (i_io_uio),
	.i_io_din     (i_io_din),
	.i_led_user   (i_led_user),
	.i_led_disk   (i_led_disk),
	.i_led_power  (i_led_power),
	.o_io_ack     (o_io_ack),
	.o_tx_hs      (o_tx_hs),
	.o_tx_vs      (o_tx_vs),
	.o_tx_de      (o_tx_de),
	.o_video_sync (o_video_sync),
	.o_led        (o_led)
);

// ==== tests/tb_sys_video_top.sv ====
// Video core testbench
// Small frame generator with active low syncs, host transactions
// on the strobe and acknowledge port, LCG driven LED words.
// Checking is done by the bound assertion module.

`timescale 1ns/1ps

module sync_gen (
	input  logic clk_sys,
	input  logic resetd,
	output logic o_hs,
	output logic o_vs,
	output logic o_de
);
	localparam int H_TOTAL    = 40;
	localparam int H_SYNC     = 4;
	localparam int H_DE_START = 10;
	localparam int H_DE_END   = 36;
	localparam int V_TOTAL    = 20;
	localparam int V_SYNC     = 2;
	localparam int V_DE_START = 4;
	localparam int V_DE_END   = 18;

	int   h;
	int   v;
	// Idle levels from time zero
	logic hs_q = 1'b1;
	logic vs_q = 1'b1;
	logic de_q = 1'b0;

	assign o_hs = hs_q;
	assign o_vs = vs_q;
	assign o_de = de_q;

	// Inputs of the DUT move on the falling edge
	always @(negedge clk_sys) begin
		if (resetd) begin
			h    <= 0;
			v    <= 0;
			hs_q <= 1'b1;
			vs_q <= 1'b1;
			de_q <= 1'b0;
		end else begin
			hs_q <= (h >= H_SYNC);
			vs_q <= (v >= V_SYNC);
			de_q <= (h >= H_DE_START) && (h < H_DE_END) && (v >= V_DE_START) &&
				(v < V_DE_END);
			if (h == H_TOTAL - 1) begin
				h <= 0;
				v <= (v == V_TOTAL - 1) ? 0 : v + 1;
			end else begin
				h <= h + 1;
			end
		end
	end

endmodule

module tb_sys_video_top;
	import sys_video_pkg::*;

	localparam int FRAME_CYC = 800;
	localparam int ACK_LIMIT = 20;

	logic                clk_sys;
	logic                resetd;
	logic                hs_in;
	logic                vs_in;
	logic                de_in;
	logic                io_clk;
	logic                io_uio;
	io_word_t            io_din;
	logic                led_user;
	logic                led_disk;
	logic                led_power;
	logic                io_ack;
	logic                tx_hs;
	logic                tx_vs;
	logic                tx_de;
	logic                video_sync;
	logic [LED_W-1:0]    led;
	logic [31:0]         lcg_state;

	sync_gen sync_gen_inst (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.o_hs    (hs_in),
		.o_vs    (vs_in),
		.o_de    (de_in)
	);

	sys_video_top sys_video_top_inst (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_hs         (hs_in),
		.i_vs         (vs_in),
		.i_de         (de_in),
		.i_io_clk     (io_clk),
		.i_io_uio     (io_uio),
		.i_io_din     (io_din),
		.i_led_user   (led_user),
		.i_led_disk   (led_disk),
		.i_led_power  (led_power),
		.o_io_ack     (io_ack),
		.o_tx_hs      (tx_hs),
		.o_tx_vs      (tx_vs),
		.o_tx_de      (tx_de),
		.o_video_sync (video_sync),
		.o_led        (led)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic timeout_fail(input string what);
		$display("Timeout while waiting for %s", what);
		$display("TEST FAILED");
		$fatal(1, "timeout");
	endtask

	task automatic wait_ack(input logic level, input int limit);
		int n;
		n = 0;
		while (io_ack !== level) begin
			@(negedge clk_sys);
			n++;
			if (n > limit) begin
				timeout_fail("o_io_ack");
			end
		end
	endtask

	task automatic wait_frames(input int count);
		int seen;
		int cycles;
		logic prev;
		seen   = 0;
		cycles = 0;
		prev   = vs_in;
		while (seen < count) begin
			@(negedge clk_sys);
			cycles++;
			if (prev && !vs_in) begin
				seen++;
			end
			prev = vs_in;
			if (cycles > (count + 1) * FRAME_CYC) begin
				timeout_fail("vsync");
			end
		end
	endtask

	// One word: raise the strobe, wait for the echo, drop it again
	task automatic send_word(input io_word_t w, input int fall_limit);
		@(negedge clk_sys);
		io_din = w;
		io_clk = 1'b1;
		wait_ack(1'b1, ACK_LIMIT);
		@(negedge clk_sys);
		io_clk = 1'b0;
		wait_ack(1'b0, fall_limit);
	endtask

	task automatic host_cmd(input host_cmd_e cmd, input io_word_t data, input bit with_data);
		@(negedge clk_sys);
		io_uio = 1'b1;
		send_word({8'h00, cmd}, 2 * FRAME_CYC);
		if (with_data) begin
			send_word(data, ACK_LIMIT);
		end
		@(negedge clk_sys);
		io_uio = 1'b0;
	endtask

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// Stop at the first failed assertion
	always @(negedge clk_sys) begin
		if (sys_video_top_inst.sys_video_assertions_inst.fail_cnt != 0) begin
			$display("TEST FAILED");
			$fatal(1, "assertion failure");
		end
	end

	initial begin
		resetd    = 1'b1;
		io_clk    = 1'b0;
		io_uio    = 1'b0;
		io_din    = '0;
		led_user  = 1'b0;
		led_disk  = 1'b0;
		led_power = 1'b0;
		lcg_state = 32'd17976;
		repeat (16) @(negedge clk_sys);
		resetd = 1'b0;
		wait_frames(3);

		// LED takeover with random words and inputs
		repeat (8) begin
			lcg_state = lcg_next(lcg_state);
			@(negedge clk_sys);
			led_user  = lcg_state[29];
			led_disk  = lcg_state[30];
			led_power = lcg_state[31];
			host_cmd(CMD_LED, lcg_state[23:8], 1'b1);
		end

		// Composite sync on for two frames
		host_cmd(CMD_CFG, 16'h0001 << CFG_CSYNC_BIT, 1'b1);
		wait_frames(2);
		host_cmd(CMD_CFG, 16'h0000, 1'b1);
		wait_frames(1);

		repeat (2) host_cmd(CMD_VS_WAIT, 16'h0000, 1'b0);

		host_cmd(CMD_VS_LINE, 16'd5, 1'b1);
		wait_frames(3);
		host_cmd(CMD_VS_LINE, 16'd11, 1'b1);
		wait_frames(3);

		repeat (4) @(negedge clk_sys);
		if (sys_video_top_inst.sys_video_assertions_inst.fail_cnt != 0) begin
			$display("TEST FAILED");
			$fatal(1, "assertion failure");
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

// ==== all.f ====
source/sys_video_pkg.sv
source/video_if.sv
source/host_ctrl.sv
source/sync_polarity_fix.sv
source/csync_gen.sv
source/line_sync_marker.sv
source/video_out.sv
source/sys_video_top.sv
tests/sys_video_assertions.sv
tests/tb_sys_video_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the video core simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f \
	--top-module tb_sys_video_top -o sim_tb

./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASSED$" sim.log; then
	exit 0
else
	exit 1
fi
